// ==== logic/intf_defines.svh ====
// Data path widths, timer address map, timer register offsets and reset values
`ifndef INTF_DEFINES_SVH
`define INTF_DEFINES_SVH

// ---------------------------------------------------------
// Data path
// ---------------------------------------------------------
`define DMEM_AWIDTH         32
`define DMEM_DWIDTH         32
`define WB_SEL_WIDTH        4           // One enable per byte lane

// ---------------------------------------------------------
// Timer address map
// ---------------------------------------------------------
`define TIMER_BASE          32'h0049_0000
`define TIMER_MASK          32'hFFFF_FFE0   // 32 byte timer window
`define TIMER_OFS_WIDTH     5               // Offset bits inside the window
`define TIMER_OFS_CTRL      5'h00
`define TIMER_OFS_DIV       5'h04
`define TIMER_OFS_MTIME_LO  5'h08
`define TIMER_OFS_MTIME_HI  5'h0C
`define TIMER_OFS_CMP_LO    5'h10
`define TIMER_OFS_CMP_HI    5'h14

// Timer register widths and reset values
`define TIMER_DIV_WIDTH     10
`define TIMER_CTRL_RST      1'b1                    // Counting out of reset
`define TIMER_DIV_RST       10'd0
`define TIMER_MTIME_RST     64'd0
`define TIMER_CMP_RST       64'hFFFF_FFFF_FFFF_FFFF // Keeps irq low
`endif

// ==== logic/intf_pkg.sv ====
// Shared typedefs, command/width/response enums and request structs
`include "intf_defines.svh"

package intf_pkg;

    // ---------------------------------------------------------
    // Vector types
    // ---------------------------------------------------------
    typedef logic [`DMEM_AWIDTH-1:0]     mem_addr_t;
    typedef logic [`DMEM_DWIDTH-1:0]     mem_data_t;
    typedef logic [`WB_SEL_WIDTH-1:0]    wb_sel_t;     // Byte enables
    typedef logic [`TIMER_DIV_WIDTH-1:0] timer_div_t;
    typedef logic [63:0]                 timer_val_t;  // Machine time

    // Core protocol encodings
    typedef enum logic {
        MEM_CMD_READ  = 1'b0,
        MEM_CMD_WRITE = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'd0,
        MEM_WIDTH_HWORD = 2'd1,
        MEM_WIDTH_WORD  = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'd0,     // No response this cycle
        MEM_RESP_RDY_OK = 2'd1,
        MEM_RESP_RDY_ER = 2'd2
    } mem_resp_e;

    // ---------------------------------------------------------
    // Request bundles
    // ---------------------------------------------------------
    typedef struct packed {
        mem_cmd_e   cmd;
        mem_width_e width;
        mem_addr_t  addr;
        mem_data_t  wdata;
    } dmem_req_t;                   // 67 bits

    typedef struct packed {
        mem_addr_t  adr;
        logic       we;
        mem_data_t  dat;
        wb_sel_t    sel;
    } wb_req_t;                     // 69 bits

    typedef enum logic [1:0] {
        BR_IDLE = 2'd0,             // Waiting for a core request
        BR_BUS  = 2'd1,             // Wishbone cycle in progress
        BR_RESP = 2'd2              // Response to the core
    } bridge_state_e;

endpackage

// ==== logic/dmem_router.sv ====
// Data memory router: timer/bus address decode, request steering, response return
`timescale 1ns/1ns
`include "intf_defines.svh"

module dmem_router (
    input  logic                 core_clk,
    input  logic                 reset_i,
    // Core side
    input  logic                 req_i,
    input  intf_pkg::dmem_req_t  req_s_i,
    output logic                 req_ack_o,
    output intf_pkg::mem_data_t  rdata_o,
    output intf_pkg::mem_resp_e  resp_o,
    // Timer port
    output logic                 timer_req_o,
    output intf_pkg::dmem_req_t  timer_req_s_o,
    input  logic                 timer_req_ack_i,
    input  intf_pkg::mem_data_t  timer_rdata_i,
    input  intf_pkg::mem_resp_e  timer_resp_i,
    // Bus bridge port
    output logic                 bus_req_o,
    output intf_pkg::dmem_req_t  bus_req_s_o,
    input  logic                 bus_req_ack_i,
    input  intf_pkg::mem_data_t  bus_rdata_i,
    input  intf_pkg::mem_resp_e  bus_resp_i
);
    import intf_pkg::*;

    logic       hit_timer;      // Address falls in the timer window
    logic       busy_q;         // Response outstanding
    logic       sel_timer_q;    // Port of the outstanding transaction
    logic       accept;
    mem_resp_e  port_resp;

    assign hit_timer = ((req_s_i.addr & `TIMER_MASK) == `TIMER_BASE);

    // ---------------------------------------------------------
    // Request steering
    // ---------------------------------------------------------
    assign timer_req_o   = req_i & ~busy_q & hit_timer;
    assign bus_req_o     = req_i & ~busy_q & ~hit_timer;
    assign timer_req_s_o = req_s_i;     // Payload goes to both ports
    assign bus_req_s_o   = req_s_i;

    // Ack held low while busy so only one item is in flight
    assign req_ack_o = ~busy_q & (hit_timer ? timer_req_ack_i : bus_req_ack_i);
    assign accept    = req_i & req_ack_o;

    // Response comes back from the port that took the request
    assign port_resp = sel_timer_q ? timer_resp_i : bus_resp_i;
    assign resp_o    = busy_q ? port_resp : MEM_RESP_IDLE;
    assign rdata_o   = sel_timer_q ? timer_rdata_i : bus_rdata_i;

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            sel_timer_q <= 1'b0;
        end else if (accept) begin
            busy_q      <= 1'b1;
            sel_timer_q <= hit_timer;   // Remember target until its resp
        end else if (busy_q && (port_resp != MEM_RESP_IDLE)) begin
            busy_q      <= 1'b0;        // Single response cycle seen
        end
    end

endmodule

// ==== logic/mem_timer.sv ====
// Memory-mapped machine timer with clock divider, compare register and interrupt
`timescale 1ns/1ns
`include "intf_defines.svh"

module mem_timer (
    input  logic                  core_clk,
    input  logic                  reset_i,
    // Core protocol slave
    input  logic                  req_i,
    input  intf_pkg::dmem_req_t   req_s_i,
    output logic                  req_ack_o,
    output intf_pkg::mem_data_t   rdata_o,
    output intf_pkg::mem_resp_e   resp_o,
    // Timer outputs
    output intf_pkg::timer_val_t  timer_val_o,
    output logic                  timer_irq_o
);
    import intf_pkg::*;

    logic [`TIMER_OFS_WIDTH-1:0] ofs;   // Register offset in window
    logic        ofs_ok;
    logic        acc_ok;                // Word access to a known register
    logic        wr_en;
    logic        tick;                  // mtime advance strobe
    logic        ctrl_en_q;
    timer_div_t  div_q;
    timer_div_t  div_cnt_q;
    timer_val_t  mtime_q;
    timer_val_t  mtimecmp_q;
    mem_data_t   rd_mux;
    mem_data_t   rdata_q;
    mem_resp_e   resp_q;
    logic        irq_q;

    assign ofs       = req_s_i.addr[`TIMER_OFS_WIDTH-1:0];
    assign req_ack_o = 1'b1;            // Always ready

    // ---------------------------------------------------------
    // Register read mux and offset check
    // ---------------------------------------------------------
    always_comb begin
        ofs_ok = 1'b1;
        rd_mux = '0;
        case (ofs)
            `TIMER_OFS_CTRL:     rd_mux = mem_data_t'(ctrl_en_q);
            `TIMER_OFS_DIV:      rd_mux = mem_data_t'(div_q);
            `TIMER_OFS_MTIME_LO: rd_mux = mtime_q[31:0];
            `TIMER_OFS_MTIME_HI: rd_mux = mtime_q[63:32];
            `TIMER_OFS_CMP_LO:   rd_mux = mtimecmp_q[31:0];
            `TIMER_OFS_CMP_HI:   rd_mux = mtimecmp_q[63:32];
            default:             ofs_ok = 1'b0;
        endcase
    end

    assign acc_ok = ofs_ok && (req_s_i.width == MEM_WIDTH_WORD);
    assign wr_en  = req_i && acc_ok && (req_s_i.cmd == MEM_CMD_WRITE);
    assign tick   = ctrl_en_q && (div_cnt_q == div_q);  // Every div+1 clocks

    // ---------------------------------------------------------
    // Control, divider and counters
    // ---------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            ctrl_en_q  <= `TIMER_CTRL_RST;
            div_q      <= `TIMER_DIV_RST;
            div_cnt_q  <= '0;
            mtime_q    <= `TIMER_MTIME_RST;
            mtimecmp_q <= `TIMER_CMP_RST;
        end else begin
            if (wr_en && (ofs == `TIMER_OFS_CTRL)) begin
                ctrl_en_q <= req_s_i.wdata[0];  // Bit 0 enable
            end
            if (wr_en && (ofs == `TIMER_OFS_DIV)) begin
                div_q     <= req_s_i.wdata[`TIMER_DIV_WIDTH-1:0];
                div_cnt_q <= '0;                // Restart prescaler
            end else if (ctrl_en_q) begin
                div_cnt_q <= tick ? '0 : timer_div_t'(div_cnt_q + 1'b1);
            end
            // Software write wins over the increment
            if (wr_en && (ofs == `TIMER_OFS_MTIME_LO)) begin
                mtime_q[31:0] <= req_s_i.wdata;
            end else if (wr_en && (ofs == `TIMER_OFS_MTIME_HI)) begin
                mtime_q[63:32] <= req_s_i.wdata;
            end else if (tick) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_en && (ofs == `TIMER_OFS_CMP_LO)) begin
                mtimecmp_q[31:0] <= req_s_i.wdata;
            end
            if (wr_en && (ofs == `TIMER_OFS_CMP_HI)) begin
                mtimecmp_q[63:32] <= req_s_i.wdata;
            end
        end
    end

    // Response one cycle after accept
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            resp_q <= MEM_RESP_IDLE;
            irq_q  <= 1'b0;
        end else begin
            resp_q <= !req_i ? MEM_RESP_IDLE :
                      acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
            irq_q  <= (mtime_q >= mtimecmp_q);  // Level irq, one cycle late
        end
    end

    always_ff @(posedge core_clk) begin
        if (req_i) begin
            rdata_q <= rd_mux;          // Zero on a bad offset
        end
    end

    assign rdata_o     = rdata_q;
    assign resp_o      = resp_q;
    assign timer_val_o = mtime_q;
    assign timer_irq_o = irq_q;

endmodule

// ==== logic/dmem_wb_bridge.sv ====
// Core data request to single Wishbone cycle bridge with byte lane steering
`timescale 1ns/1ns

module dmem_wb_bridge (
    input  logic                 core_clk,
    input  logic                 reset_i,
    // Core protocol slave
    input  logic                 req_i,
    input  intf_pkg::dmem_req_t  req_s_i,
    output logic                 req_ack_o,
    output intf_pkg::mem_data_t  rdata_o,
    output intf_pkg::mem_resp_e  resp_o,
    // Wishbone master
    output logic                 wbd_stb_o,
    output intf_pkg::wb_req_t    wbd_o,
    input  intf_pkg::mem_data_t  wbd_dat_i,
    input  logic                 wbd_ack_i,
    input  logic                 wbd_err_i
);
    import intf_pkg::*;

    bridge_state_e state_q;
    wb_req_t       wb_next;
    wb_req_t       wb_q;        // Request held for the whole bus cycle
    mem_data_t     rdata_q;
    logic          err_q;
    logic          accept;
    logic          bus_done;

    // Byte enables from access width and low address bits
    function automatic wb_sel_t lane_sel(mem_width_e width, logic [1:0] lsb);
        wb_sel_t sel;
        case (width)
            MEM_WIDTH_BYTE:  sel = wb_sel_t'(1) << lsb;
            MEM_WIDTH_HWORD: sel = lsb[1] ? 4'b1100 : 4'b0011;
            default:         sel = '1;
        endcase
        return sel;
    endfunction

    // Write data moved onto the addressed lanes, other lanes zero
    function automatic mem_data_t lane_dat(mem_width_e width, logic [1:0] lsb,
                                           mem_data_t wdata);
        mem_data_t dat;
        case (width)
            MEM_WIDTH_BYTE:  dat = mem_data_t'(wdata[7:0]) << {lsb, 3'b000};
            MEM_WIDTH_HWORD: dat = mem_data_t'(wdata[15:0]) << {lsb[1], 4'b0000};
            default:         dat = wdata;
        endcase
        return dat;
    endfunction

    always_comb begin
        wb_next.adr = req_s_i.addr;     // Full byte address
        wb_next.we  = (req_s_i.cmd == MEM_CMD_WRITE);
        wb_next.dat = lane_dat(req_s_i.width, req_s_i.addr[1:0], req_s_i.wdata);
        wb_next.sel = lane_sel(req_s_i.width, req_s_i.addr[1:0]);
    end

    assign req_ack_o = (state_q == BR_IDLE);
    assign accept    = req_i & req_ack_o;
    assign wbd_stb_o = (state_q == BR_BUS);
    assign bus_done  = wbd_stb_o & (wbd_ack_i | wbd_err_i);

    // ---------------------------------------------------------
    // Bridge FSM
    // ---------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            state_q <= BR_IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                BR_IDLE: begin
                    if (accept) state_q <= BR_BUS;
                end
                BR_BUS: begin
                    if (bus_done) begin
                        state_q <= BR_RESP;
                        err_q   <= wbd_err_i;   // Error wins over ack
                    end
                end
                default: state_q <= BR_IDLE;    // One response cycle
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) wb_q <= wb_next;
        if (bus_done) rdata_q <= wbd_dat_i;    // Returned unshifted
    end

    assign wbd_o   = wb_q;
    assign rdata_o = rdata_q;
    assign resp_o  = (state_q != BR_RESP) ? MEM_RESP_IDLE :
                     err_q ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;

endmodule

// ==== logic/intf_top.sv ====
// Data memory interface top: router, machine timer and Wishbone bridge
`timescale 1ns/1ns

module intf_top (
    input  logic                  core_clk,
    input  logic                  reset_i,
    // Core data port
    input  logic                  core_dmem_req_i,
    input  intf_pkg::dmem_req_t   core_dmem_req_s_i,
    output logic                  core_dmem_req_ack_o,
    output intf_pkg::mem_data_t   core_dmem_rdata_o,
    output intf_pkg::mem_resp_e   core_dmem_resp_o,
    // Wishbone data bus
    output logic                  wbd_dmem_stb_o,
    output intf_pkg::wb_req_t     wbd_dmem_o,
    input  intf_pkg::mem_data_t   wbd_dmem_dat_i,
    input  logic                  wbd_dmem_ack_i,
    input  logic                  wbd_dmem_err_i,
    // Timer
    output intf_pkg::timer_val_t  timer_val_o,
    output logic                  timer_irq_o
);
    import intf_pkg::*;

    // ---------------------------------------------------------
    // Router to timer
    // ---------------------------------------------------------
    logic       timer_req;
    dmem_req_t  timer_req_s;
    logic       timer_req_ack;
    mem_data_t  timer_rdata;
    mem_resp_e  timer_resp;

    // Router to bridge
    logic       bus_req;
    dmem_req_t  bus_req_s;
    logic       bus_req_ack;
    mem_data_t  bus_rdata;
    mem_resp_e  bus_resp;

    dmem_router dmem_router_inst (
        .core_clk        (core_clk),
        .reset_i         (reset_i),
        .req_i           (core_dmem_req_i),
        .req_s_i         (core_dmem_req_s_i),
        .req_ack_o       (core_dmem_req_ack_o),
        .rdata_o         (core_dmem_rdata_o),
        .resp_o          (core_dmem_resp_o),
        .timer_req_o     (timer_req),
        .timer_req_s_o   (timer_req_s),
        .timer_req_ack_i (timer_req_ack),
        .timer_rdata_i   (timer_rdata),
        .timer_resp_i    (timer_resp),
        .bus_req_o       (bus_req),
        .bus_req_s_o     (bus_req_s),
        .bus_req_ack_i   (bus_req_ack),
        .bus_rdata_i     (bus_rdata),
        .bus_resp_i      (bus_resp)
    );

    mem_timer mem_timer_inst (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .req_i       (timer_req),
        .req_s_i     (timer_req_s),
        .req_ack_o   (timer_req_ack),
        .rdata_o     (timer_rdata),
        .resp_o      (timer_resp),
        .timer_val_o (timer_val_o),
        .timer_irq_o (timer_irq_o)
    );

    dmem_wb_bridge dmem_wb_bridge_inst (
        .core_clk  (core_clk),
        .reset_i   (reset_i),
        .req_i     (bus_req),
        .req_s_i   (bus_req_s),
        .req_ack_o (bus_req_ack),
        .rdata_o   (bus_rdata),
        .resp_o    (bus_resp),
        .wbd_stb_o (wbd_dmem_stb_o),
        .wbd_o     (wbd_dmem_o),
        .wbd_dat_i (wbd_dmem_dat_i),
        .wbd_ack_i (wbd_dmem_ack_i),
        .wbd_err_i (wbd_dmem_err_i)
    );

endmodule

// ==== testbench/intf_chk.sv ====
// Concurrent protocol assertions for intf_top attached with bind
`timescale 1ns/1ns

module intf_chk (
    input logic                 core_clk,
    input logic                 reset_i,
    input logic                 core_dmem_req_i,
    input logic                 core_dmem_req_ack_o,
    input intf_pkg::mem_resp_e  core_dmem_resp_o,
    input logic                 wbd_dmem_stb_o,
    input intf_pkg::wb_req_t    wbd_dmem_o,
    input logic                 wbd_dmem_ack_i,
    input logic                 wbd_dmem_err_i
);
    import intf_pkg::*;

    logic accept;
    logic pending_q;            // Accepted but response not yet seen
    int   assert_fails = 0;     // Failed assertion count

    assign accept = core_dmem_req_i & core_dmem_req_ack_o;

    always_ff @(posedge core_clk) begin
        if (reset_i) pending_q <= 1'b0;
        else if (accept) pending_q <= 1'b1;
        else if (core_dmem_resp_o != MEM_RESP_IDLE) pending_q <= 1'b0;
    end

    // ------------------------------------------------------------
    // Wishbone cycle held until ack or err
    stb_held: assert property (@(posedge core_clk) disable iff (reset_i)
        wbd_dmem_stb_o && !(wbd_dmem_ack_i || wbd_dmem_err_i) |=>
            wbd_dmem_stb_o && $stable(wbd_dmem_o))
        else begin
            assert_fails++;
            $error("stb dropped or request changed before ack");
        end

    // One response per accept
    resp_follows: assert property (@(posedge core_clk) disable iff (reset_i)
        accept |-> ##[1:20] (core_dmem_resp_o != MEM_RESP_IDLE))
        else begin
            assert_fails++;
            $error("accepted request got no response");
        end

    resp_single: assert property (@(posedge core_clk) disable iff (reset_i)
        (core_dmem_resp_o != MEM_RESP_IDLE) |-> pending_q)
        else begin
            assert_fails++;
            $error("response without an outstanding request");
        end

    ack_blocked: assert property (@(posedge core_clk) disable iff (reset_i)
        pending_q |-> !core_dmem_req_ack_o)
        else begin
            assert_fails++;
            $error("req_ack high while a response is outstanding");
        end

endmodule

bind intf_top intf_chk intf_chk_inst (.*);

// ==== testbench/tb_intf_top.sv ====
// Testbench for intf_top with clock and reset, Wishbone slave model, directed tests and watchdog
`timescale 1ns/1ns
`include "intf_defines.svh"

module tb_intf_top;
    import intf_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 300;       // Upper bound for one test
    localparam int WAIT_LIMIT  = 50;        // Per handshake

    logic        core_clk;
    logic        reset_i;
    logic        core_dmem_req_i;
    dmem_req_t   core_dmem_req_s_i;
    logic        core_dmem_req_ack_o;
    mem_data_t   core_dmem_rdata_o;
    mem_resp_e   core_dmem_resp_o;
    logic        wbd_dmem_stb_o;
    wb_req_t     wbd_dmem_o;
    mem_data_t   wbd_dmem_dat_i;
    logic        wbd_dmem_ack_i;
    logic        wbd_dmem_err_i;
    timer_val_t  timer_val_o;
    logic        timer_irq_o;

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycle_cnt = 0;
    wb_req_t     wb_seen;                   // Last request the model answered
    mem_data_t   wb_mem [0:15];

    intf_top intf_top_inst (.*);

    initial core_clk = 1'b0;
    always #5 core_clk = ~core_clk;
    always @(posedge core_clk) cycle_cnt++;

    // Initial model contents depend on the word index
    function automatic mem_data_t fill_word(input logic [3:0] idx);
        return 32'h6B00_0000 ^ ({28'd0, idx} * 32'h0011_1111);
    endfunction

    // ------------------------------------------------------------
    // Wishbone slave model with 0 to 3 wait cycles
    // ------------------------------------------------------------
    initial begin
        int  wait_left;
        bit  in_cycle;
        void'($urandom(32'h7f0d4d65));
        for (int i = 0; i < 16; i++) wb_mem[i] = fill_word(4'(i));
        wbd_dmem_ack_i = 1'b0;
        wbd_dmem_err_i = 1'b0;
        wbd_dmem_dat_i = '0;
        in_cycle       = 1'b0;
        wait_left      = 0;
        forever begin
            @(posedge core_clk);
            #1;
            wbd_dmem_ack_i = 1'b0;
            wbd_dmem_err_i = 1'b0;
            if (wbd_dmem_stb_o) begin
                if (!in_cycle) begin
                    in_cycle  = 1'b1;
                    wait_left = $urandom_range(3, 0);
                end
                if (wait_left == 0) begin
                    in_cycle = 1'b0;
                    wb_seen  = wbd_dmem_o;
                    if (wbd_dmem_o.adr[28]) begin
                        wbd_dmem_err_i = 1'b1;      // Error region
                    end else begin
                        for (int b = 0; b < 4; b++) begin
                            if (wbd_dmem_o.we && wbd_dmem_o.sel[b])
                                wb_mem[wbd_dmem_o.adr[5:2]][b*8 +: 8] = wbd_dmem_o.dat[b*8 +: 8];
                        end
                        wbd_dmem_dat_i = wb_mem[wbd_dmem_o.adr[5:2]];
                        wbd_dmem_ack_i = 1'b1;
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One core transaction entered and left 1 ns after a rising edge
    task automatic access(input mem_cmd_e cmd, input mem_width_e width, input mem_addr_t addr,
                          input mem_data_t wdata, output mem_resp_e resp, output mem_data_t rdata);
        int waited;
        waited = 0;
        core_dmem_req_i   = 1'b1;
        core_dmem_req_s_i = '{cmd: cmd, width: width, addr: addr, wdata: wdata};
        @(negedge core_clk);
        while (!core_dmem_req_ack_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge core_clk);
        end
        @(posedge core_clk);                // Accept edge
        #1;
        core_dmem_req_i = 1'b0;
        @(negedge core_clk);
        while (core_dmem_resp_o == MEM_RESP_IDLE && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge core_clk);
        end
        if (waited >= WAIT_LIMIT) begin
            errors++;
            $display("Timeout: no handshake from the DUT for address %h", addr);
        end
        resp  = core_dmem_resp_o;
        rdata = core_dmem_rdata_o;
        @(posedge core_clk);
        #1;
    endtask

    task automatic timer_write(input logic [4:0] ofs, input mem_data_t data);
        mem_resp_e resp;
        mem_data_t rdata;
        access(MEM_CMD_WRITE, MEM_WIDTH_WORD, `TIMER_BASE | ofs, data, resp, rdata);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_OK);
    endtask

    task automatic timer_read(input logic [4:0] ofs, output mem_data_t data);
        mem_resp_e resp;
        access(MEM_CMD_READ, MEM_WIDTH_WORD, `TIMER_BASE | ofs, '0, resp, data);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_OK);
    endtask

    // Bus access plus checks of the request the model saw
    task automatic bus_op(input mem_cmd_e cmd, input mem_width_e width, input mem_addr_t addr,
                          input mem_data_t wdata, input logic [3:0] exp_sel,
                          input mem_data_t exp_dat);
        mem_resp_e resp;
        mem_data_t rdata;
        access(cmd, width, addr, wdata, resp, rdata);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_OK);
        compare("wbd_dmem_o.adr", wb_seen.adr, addr);
        compare("wbd_dmem_o.we", wb_seen.we, cmd == MEM_CMD_WRITE);
        compare("wbd_dmem_o.sel", wb_seen.sel, exp_sel);
        if (cmd == MEM_CMD_WRITE) compare("wbd_dmem_o.dat", wb_seen.dat, exp_dat);
        else compare("core_dmem_rdata_o", rdata, exp_dat);     // Full word unshifted
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        $display("%-22s %s", name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic timer_reg_access();
        int        e0 = errors;
        mem_data_t rd;
        timer_read(`TIMER_OFS_CTRL, rd);
        compare("ctrl", rd, 32'h1);         // Enabled out of reset
        timer_write(`TIMER_OFS_CMP_LO, 32'hDEAD_BEEF);
        timer_write(`TIMER_OFS_CMP_HI, 32'h1234_5678);
        timer_write(`TIMER_OFS_DIV, 32'h155);
        timer_read(`TIMER_OFS_CMP_LO, rd);
        compare("mtimecmp_lo", rd, 32'hDEAD_BEEF);
        timer_read(`TIMER_OFS_CMP_HI, rd);
        compare("mtimecmp_hi", rd, 32'h1234_5678);
        timer_read(`TIMER_OFS_DIV, rd);
        compare("div", rd, 32'h155);
        report_test("timer register access", e0);
    endtask

    task automatic timer_hold();
        int        e0 = errors;
        int        c0;
        mem_data_t t0;
        mem_data_t t1;
        timer_write(`TIMER_OFS_CTRL, 32'h0);
        timer_write(`TIMER_OFS_MTIME_LO, 32'h1234);
        timer_write(`TIMER_OFS_MTIME_HI, 32'h0);
        repeat (20) @(posedge core_clk);
        #1;
        timer_read(`TIMER_OFS_MTIME_LO, t0);
        compare("mtime_lo", t0, 32'h1234);
        timer_read(`TIMER_OFS_MTIME_HI, t1);
        compare("mtime_hi", t1, 32'h0);
        compare("timer_val_o", timer_val_o, 64'h1234);
        timer_write(`TIMER_OFS_DIV, 32'd3);         // One tick per 4 clocks
        timer_write(`TIMER_OFS_CTRL, 32'h1);
        timer_read(`TIMER_OFS_MTIME_LO, t0);
        c0 = cycle_cnt;
        repeat (40) @(posedge core_clk);
        #1;
        timer_read(`TIMER_OFS_MTIME_LO, t1);
        compare("mtime advanced", t1 > t0, 1'b1);
        compare("mtime rate ok", (t1 - t0) <= (cycle_cnt - c0) / 4 + 1, 1'b1);
        report_test("timer hold and value", e0);
    endtask

    task automatic timer_interrupt();
        int e0 = errors;
        bit irq_seen = 1'b0;
        timer_write(`TIMER_OFS_CTRL, 32'h0);
        timer_write(`TIMER_OFS_MTIME_LO, 32'h80);
        timer_write(`TIMER_OFS_MTIME_HI, 32'h0);
        timer_write(`TIMER_OFS_CMP_HI, 32'h0);
        timer_write(`TIMER_OFS_CMP_LO, 32'h100);
        repeat (3) @(negedge core_clk);
        compare("timer_irq_o", timer_irq_o, 1'b0);
        @(posedge core_clk);
        #1;
        timer_write(`TIMER_OFS_MTIME_LO, 32'h100);  // mtime == mtimecmp
        repeat (2) begin
            @(negedge core_clk);
            if (timer_irq_o) irq_seen = 1'b1;
        end
        compare("timer_irq_o", irq_seen, 1'b1);
        @(posedge core_clk);
        #1;
        report_test("timer interrupt", e0);
    endtask

    task automatic timer_errors();
        int        e0 = errors;
        mem_resp_e resp;
        mem_data_t rd;
        access(MEM_CMD_WRITE, MEM_WIDTH_BYTE, `TIMER_BASE | `TIMER_OFS_CMP_LO, 32'hFF, resp, rd);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_ER);
        access(MEM_CMD_WRITE, MEM_WIDTH_WORD, `TIMER_BASE | 32'h18, 32'h5555, resp, rd);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_ER);
        access(MEM_CMD_READ, MEM_WIDTH_BYTE, `TIMER_BASE | `TIMER_OFS_CTRL, '0, resp, rd);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_ER);
        timer_read(`TIMER_OFS_CMP_LO, rd);
        compare("mtimecmp_lo", rd, 32'h100);        // Untouched
        timer_read(`TIMER_OFS_CTRL, rd);
        compare("ctrl", rd, 32'h0);
        report_test("timer errors", e0);
    endtask

    task automatic bus_transfers();
        int e0 = errors;
        bus_op(MEM_CMD_WRITE, MEM_WIDTH_WORD,  32'h2010, 32'hCAFE_F00D, 4'hF, 32'hCAFE_F00D);
        bus_op(MEM_CMD_READ,  MEM_WIDTH_WORD,  32'h2010, 32'h0,         4'hF, 32'hCAFE_F00D);
        bus_op(MEM_CMD_WRITE, MEM_WIDTH_HWORD, 32'h2012, 32'h1234_BEEF, 4'hC, 32'hBEEF_0000);
        bus_op(MEM_CMD_WRITE, MEM_WIDTH_BYTE,  32'h2011, 32'h0000_775A, 4'h2, 32'h0000_5A00);
        bus_op(MEM_CMD_READ,  MEM_WIDTH_HWORD, 32'h2012, 32'h0,         4'hC, 32'hBEEF_5A0D);
        bus_op(MEM_CMD_READ,  MEM_WIDTH_BYTE,  32'h2017, 32'h0,         4'h8, fill_word(4'd5));
        report_test("bus transfers", e0);
    endtask

    task automatic bus_error();
        int        e0 = errors;
        mem_resp_e resp;
        mem_data_t rd;
        access(MEM_CMD_READ, MEM_WIDTH_WORD, 32'h1000_2010, '0, resp, rd);
        compare("core_dmem_resp_o", resp, MEM_RESP_RDY_ER);
        bus_op(MEM_CMD_READ, MEM_WIDTH_WORD, 32'h2010, 32'h0, 4'hF, 32'hBEEF_5A0D);
        report_test("bus error", e0);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        reset_i           = 1'b1;
        core_dmem_req_i   = 1'b0;
        core_dmem_req_s_i = '0;
        repeat (5) @(posedge core_clk);
        #1;
        reset_i = 1'b0;
        timer_reg_access();
        timer_hold();
        timer_interrupt();
        timer_errors();
        bus_transfers();
        bus_error();
        errors += intf_top_inst.intf_chk_inst.assert_fails;  // Protocol assertion failures
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS * TEST_CYCLES + 10) * 10);
        $display("Watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/intf_pkg.sv
logic/dmem_router.sv
logic/mem_timer.sv
logic/dmem_wb_bridge.sv
logic/intf_top.sv
testbench/intf_chk.sv
testbench/tb_intf_top.sv
